// File: hdl/corePkg.sv
package corePkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [DATA_W-1:0]     wordT;   // data word or pc
  typedef logic [REG_ADDR_W-1:0] regIdxT; // register index
  typedef logic [5:0]            codeT;   // opcode or function code

  // ALU encodings as used by the original datapath
  typedef enum logic [3:0] {
    ALU_ADDU = 4'b0000,
    ALU_SUBU = 4'b0001,
    ALU_ADD  = 4'b0010,
    ALU_SUB  = 4'b0011,
    ALU_OR   = 4'b0100,
    ALU_AND  = 4'b0101,
    ALU_XOR  = 4'b0110,
    ALU_NOR  = 4'b0111,
    ALU_SLTU = 4'b1000,
    ALU_SLT  = 4'b1001,
    ALU_SLL  = 4'b1010,
    ALU_SRL  = 4'b1011,
    ALU_SRA  = 4'b1100,
    ALU_LUI  = 4'b1101
  } aluOpT;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_LEZ  = 3'd3,
    BR_GTZ  = 3'd4
  } brKindT;

  localparam codeT OP_RTYPE = 6'b000000;
  localparam codeT OP_BEQ   = 6'b000100;
  localparam codeT OP_BNE   = 6'b000101;
  localparam codeT OP_BLEZ  = 6'b000110;
  localparam codeT OP_BGTZ  = 6'b000111;
  localparam codeT OP_ADDI  = 6'b001000;
  localparam codeT OP_ADDIU = 6'b001001;
  localparam codeT OP_SLTI  = 6'b001010;
  localparam codeT OP_SLTIU = 6'b001011;
  localparam codeT OP_ANDI  = 6'b001100;
  localparam codeT OP_ORI   = 6'b001101;
  localparam codeT OP_XORI  = 6'b001110;
  localparam codeT OP_LUI   = 6'b001111;

  localparam codeT FN_SLL  = 6'b000000;
  localparam codeT FN_SRL  = 6'b000010;
  localparam codeT FN_SRA  = 6'b000011;
  localparam codeT FN_ADD  = 6'b100000;
  localparam codeT FN_ADDU = 6'b100001;
  localparam codeT FN_SUB  = 6'b100010;
  localparam codeT FN_SUBU = 6'b100011;
  localparam codeT FN_AND  = 6'b100100;
  localparam codeT FN_OR   = 6'b100101;
  localparam codeT FN_XOR  = 6'b100110;
  localparam codeT FN_NOR  = 6'b100111;
  localparam codeT FN_SLT  = 6'b101010;
  localparam codeT FN_SLTU = 6'b101011;

endpackage

// File: hdl/pipeIfs.sv
`timescale 1ns/1ps

// decoded instruction travelling from decode into execute
interface decodedIf;
  import corePkg::*;

  logic   valid;
  aluOpT  aluOp;
  regIdxT rs;
  regIdxT rt;
  regIdxT dest;
  logic   regWrite;
  wordT   imm;      // already extended
  logic   useImm;
  wordT   shamt;    // zero-extended shift amount
  logic   useShamt;
  brKindT brKind;
  wordT   pc;
  wordT   rsData;
  wordT   rtData;

  modport producer (output valid, aluOp, rs, rt, dest, regWrite, imm, useImm,
                    shamt, useShamt, brKind, pc, rsData, rtData);
  modport consumer (input valid, aluOp, rs, rt, dest, regWrite, imm, useImm,
                    shamt, useShamt, brKind, pc, rsData, rtData);
endinterface

// writeback register contents
interface wbIf;
  import corePkg::*;

  logic   valid;
  logic   regWrite; // already qualified by valid
  regIdxT dest;
  wordT   data;

  modport producer (output valid, regWrite, dest, data);
  modport consumer (input valid, regWrite, dest, data);
endinterface

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic            clk,
  input  logic            reset,
  input  corePkg::regIdxT rdAddrA,
  input  corePkg::regIdxT rdAddrB,
  output corePkg::wordT   rdDataA,
  output corePkg::wordT   rdDataB,
  wbIf.consumer           wb
);
  import corePkg::*;

  wordT regs [0:2**REG_ADDR_W-1];
  logic wrEn;

  assign wrEn = wb.valid && wb.regWrite && (wb.dest != '0); // r0 is never stored

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < 2**REG_ADDR_W; i++)
        regs[i] <= '0;
    end
    else if (wrEn)
      regs[wb.dest] <= wb.data;
  end

  // pending write bypasses the array
  function automatic wordT readPort(input regIdxT addr);
    if (addr == '0)
      return '0;
    else if (wrEn && (wb.dest == addr))
      return wb.data;
    else
      return regs[addr];
  endfunction

  always_comb
  begin
    rdDataA = readPort(rdAddrA);
    rdDataB = readPort(rdAddrB);
  end

endmodule

// File: hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  logic            clk,
  input  logic            reset,
  input  logic            instrValid,
  input  corePkg::wordT   instr,
  input  corePkg::wordT   pc,
  output corePkg::regIdxT rdAddrA,
  output corePkg::regIdxT rdAddrB,
  input  corePkg::wordT   rdDataA,
  input  corePkg::wordT   rdDataB,
  decodedIf.producer      dec
);
  import corePkg::*;

  logic   validQ;
  wordT   instrQ;
  wordT   pcQ;
  codeT   opcode;
  codeT   funct;
  regIdxT rd;
  logic   signExt;
  logic   useRd;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      validQ <= 1'b0;
      instrQ <= '0;
      pcQ    <= '0;
    end
    else
    begin
      validQ <= instrValid;
      instrQ <= instr;
      pcQ    <= pc;
    end
  end

  assign opcode  = instrQ[31:26];
  assign funct   = instrQ[5:0];
  assign rd      = instrQ[15:11];
  assign rdAddrA = instrQ[25:21];
  assign rdAddrB = instrQ[20:16];

  always_comb
  begin
    dec.aluOp    = ALU_ADDU;
    dec.regWrite = 1'b0;
    dec.useImm   = 1'b1;
    dec.useShamt = 1'b0;
    dec.brKind   = BR_NONE;
    signExt      = 1'b1;
    useRd        = 1'b0;
    case (opcode)
      OP_RTYPE:
      begin
        useRd        = 1'b1;
        dec.useImm   = 1'b0;
        dec.regWrite = 1'b1;
        case (funct)
          FN_ADDU: dec.aluOp = ALU_ADDU;
          FN_SUBU: dec.aluOp = ALU_SUBU;
          FN_ADD:  dec.aluOp = ALU_ADD;
          FN_SUB:  dec.aluOp = ALU_SUB;
          FN_OR:   dec.aluOp = ALU_OR;
          FN_AND:  dec.aluOp = ALU_AND;
          FN_XOR:  dec.aluOp = ALU_XOR;
          FN_NOR:  dec.aluOp = ALU_NOR;
          FN_SLTU: dec.aluOp = ALU_SLTU;
          FN_SLT:  dec.aluOp = ALU_SLT;
          FN_SLL:  dec.aluOp = ALU_SLL;
          FN_SRL:  dec.aluOp = ALU_SRL;
          FN_SRA:  dec.aluOp = ALU_SRA;
          default: dec.regWrite = 1'b0; // unknown function, no write
        endcase
        dec.useShamt = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);
      end
      OP_ADDI:  {dec.aluOp, dec.regWrite} = {ALU_ADD, 1'b1};
      OP_ADDIU: {dec.aluOp, dec.regWrite} = {ALU_ADDU, 1'b1};
      OP_SLTI:  {dec.aluOp, dec.regWrite} = {ALU_SLT, 1'b1};
      OP_SLTIU: {dec.aluOp, dec.regWrite} = {ALU_SLTU, 1'b1};
      OP_ANDI:  {dec.aluOp, dec.regWrite, signExt} = {ALU_AND, 2'b10};
      OP_ORI:   {dec.aluOp, dec.regWrite, signExt} = {ALU_OR, 2'b10};
      OP_XORI:  {dec.aluOp, dec.regWrite, signExt} = {ALU_XOR, 2'b10};
      OP_LUI:   {dec.aluOp, dec.regWrite, signExt} = {ALU_LUI, 2'b10};
      OP_BEQ:   dec.brKind = BR_EQ;
      OP_BNE:   dec.brKind = BR_NE;
      OP_BLEZ:  dec.brKind = BR_LEZ;
      OP_BGTZ:  dec.brKind = BR_GTZ;
      default:  dec.useImm = 1'b0; // unsupported, travels inert
    endcase
  end

  assign dec.valid  = validQ;
  assign dec.rs     = rdAddrA;
  assign dec.rt     = rdAddrB;
  assign dec.dest   = useRd ? rd : rdAddrB;
  assign dec.imm    = signExt ? {{16{instrQ[15]}}, instrQ[15:0]} : {16'b0, instrQ[15:0]};
  assign dec.shamt  = {27'b0, instrQ[10:6]};
  assign dec.pc     = pcQ;
  assign dec.rsData = rdDataA;
  assign dec.rtData = rdDataB;

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  corePkg::wordT  a,
  input  corePkg::wordT  b,
  input  corePkg::aluOpT op,
  output corePkg::wordT  result
);
  import corePkg::*;

  logic [4:0] shAmt;

  assign shAmt = a[4:0];

  always_comb
  begin
    case (op)
      ALU_ADDU: result = a + b;
      ALU_SUBU: result = a - b;
      ALU_ADD:  result = a + b;   // wraps, no overflow trap
      ALU_SUB:  result = a - b;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      ALU_XOR:  result = a ^ b;
      ALU_NOR:  result = ~(a | b);
      ALU_SLTU: result = (a < b) ? 32'd1 : 32'd0;
      ALU_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLL:  result = b << shAmt;
      ALU_SRL:  result = b >> shAmt;
      ALU_SRA:  result = wordT'($signed(b) >>> shAmt); // sign fill
      ALU_LUI:  result = {b[15:0], 16'b0};
      default:  result = a + b;
    endcase
  end

endmodule

// File: hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic          clk,
  input  logic          reset,
  decodedIf.consumer    dec,
  wbIf.producer         wb,
  output logic          branchValid,
  output logic          branchTaken,
  output corePkg::wordT branchTarget
);
  import corePkg::*;

  logic   exValid;
  aluOpT  exAluOp;
  regIdxT exRs;
  regIdxT exRt;
  regIdxT exDest;
  logic   exRegWrite;
  wordT   exImm;
  logic   exUseImm;
  wordT   exShamt;
  logic   exUseShamt;
  brKindT exBrKind;
  wordT   exPc;
  wordT   exRsData;
  wordT   exRtData;
  logic   wbValidQ;
  logic   wbWriteQ;
  regIdxT wbDestQ;
  wordT   wbDataQ;
  logic   fwdOk;
  wordT   opRs;
  wordT   opRt;
  wordT   aluResult;
  wordT   cmpDiff;
  logic   taken;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      {exValid, exRegWrite, exUseImm, exUseShamt} <= '0;
      {exRs, exRt, exDest} <= '0;
      {exImm, exShamt, exPc, exRsData, exRtData} <= '0;
      exAluOp  <= ALU_ADDU;
      exBrKind <= BR_NONE;
    end
    else
    begin
      {exValid, exRegWrite, exUseImm, exUseShamt} <=
        {dec.valid, dec.regWrite, dec.useImm, dec.useShamt};
      {exRs, exRt, exDest} <= {dec.rs, dec.rt, dec.dest};
      {exImm, exShamt, exPc} <= {dec.imm, dec.shamt, dec.pc};
      {exRsData, exRtData} <= {dec.rsData, dec.rtData};
      exAluOp  <= dec.aluOp;
      exBrKind <= dec.brKind;
    end
  end

  // bypass from the writeback register
  assign fwdOk = wbWriteQ && (wbDestQ != '0);
  assign opRs  = (fwdOk && (wbDestQ == exRs)) ? wbDataQ : exRsData;
  assign opRt  = (fwdOk && (wbDestQ == exRt)) ? wbDataQ : exRtData;

  aluUnit i_alu (
    .a      (exUseShamt ? exShamt : opRs),
    .b      (exUseImm ? exImm : opRt),
    .op     (exAluOp),
    .result (aluResult)
  );

  // blez/bgtz compare against zero
  assign cmpDiff = opRs - (((exBrKind == BR_LEZ) || (exBrKind == BR_GTZ)) ? '0 : opRt);

  always_comb
  begin
    case (exBrKind)
      BR_EQ:   taken = (cmpDiff == '0);
      BR_NE:   taken = (cmpDiff != '0);
      BR_LEZ:  taken = (cmpDiff == '0) || cmpDiff[31];
      BR_GTZ:  taken = (cmpDiff != '0) && !cmpDiff[31];
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      {wbValidQ, wbWriteQ, branchValid, branchTaken} <= '0;
      wbDestQ      <= '0;
      wbDataQ      <= '0;
      branchTarget <= '0;
    end
    else
    begin
      wbValidQ     <= exValid;
      wbWriteQ     <= exValid && exRegWrite;
      wbDestQ      <= exDest;
      wbDataQ      <= aluResult;
      branchValid  <= exValid && (exBrKind != BR_NONE);
      branchTaken  <= exValid && taken;
      branchTarget <= exPc + 32'd4 + {exImm[29:0], 2'b00};
    end
  end

  assign wb.valid    = wbValidQ;
  assign wb.regWrite = wbWriteQ;
  assign wb.dest     = wbDestQ;
  assign wb.data     = wbDataQ;

endmodule

// File: hdl/execCore.sv
`timescale 1ns/1ps

module execCore (
  input  logic            clk,
  input  logic            reset,
  input  logic            instrValid,
  input  corePkg::wordT   instr,
  input  corePkg::wordT   pc,
  output logic            resultValid,
  output corePkg::regIdxT resultReg,
  output corePkg::wordT   resultData,
  output logic            branchValid,
  output logic            branchTaken,
  output corePkg::wordT   branchTarget
);

  decodedIf decBus ();
  wbIf      wbBus ();

  corePkg::regIdxT rdAddrA;
  corePkg::regIdxT rdAddrB;
  corePkg::wordT   rdDataA;
  corePkg::wordT   rdDataB;

  instrDecoder i_decoder (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .instr      (instr),
    .pc         (pc),
    .rdAddrA    (rdAddrA),
    .rdAddrB    (rdAddrB),
    .rdDataA    (rdDataA),
    .rdDataB    (rdDataB),
    .dec        (decBus.producer)
  );

  regFile i_regFile (
    .clk     (clk),
    .reset   (reset),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wb      (wbBus.consumer)
  );

  executeStage i_execute (
    .clk          (clk),
    .reset        (reset),
    .dec          (decBus.consumer),
    .wb           (wbBus.producer),
    .branchValid  (branchValid),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  assign resultValid = wbBus.regWrite; // r0 targets still report
  assign resultReg   = wbBus.dest;
  assign resultData  = wbBus.data;

endmodule

// File: test/coreModel.svh
`ifndef COREMODEL_SVH
`define COREMODEL_SVH

typedef enum {EXP_NONE, EXP_WRITE, EXP_BRANCH} expKindT;

typedef struct {
  string   name;
  wordT    instr;
  wordT    pc;
  expKindT kind;
  regIdxT  dest;
  wordT    data;
  logic    taken;
  wordT    target;
} rowT;

wordT shadowRegs [0:31] = '{default: '0}; // architectural registers

function automatic wordT encR(codeT fn, regIdxT rs, regIdxT rt, regIdxT rd, logic [4:0] sh);
  return {OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic wordT encI(codeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

// runs one instruction on the shadow registers and fills in the expected outputs
function automatic void modelStep(inout rowT r);
  codeT op;
  codeT fn;
  wordT a;
  wordT b;
  wordT sImm;
  wordT zImm;
  logic wr;
  op   = r.instr[31:26];
  fn   = r.instr[5:0];
  a    = shadowRegs[r.instr[25:21]];
  b    = shadowRegs[r.instr[20:16]];
  sImm = {{16{r.instr[15]}}, r.instr[15:0]};
  zImm = {16'h0000, r.instr[15:0]};
  wr   = !(op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ});
  r.dest   = (op == OP_RTYPE) ? r.instr[15:11] : r.instr[20:16];
  r.data   = '0;
  r.taken  = 1'b0;
  r.target = r.pc + 32'd4 + (sImm << 2);
  case (op)
    OP_RTYPE:
      case (fn)
        FN_ADD, FN_ADDU: r.data = a + b;
        FN_SUB, FN_SUBU: r.data = a - b;
        FN_AND:  r.data = a & b;
        FN_OR:   r.data = a | b;
        FN_XOR:  r.data = a ^ b;
        FN_NOR:  r.data = ~(a | b);
        FN_SLT:  r.data = {31'b0, $signed(a) < $signed(b)};
        FN_SLTU: r.data = {31'b0, a < b};
        FN_SLL:  r.data = b << r.instr[10:6];
        FN_SRL:  r.data = b >> r.instr[10:6];
        FN_SRA:  r.data = $signed(b) >>> r.instr[10:6];
        default: wr = 1'b0;
      endcase
    OP_ADDI, OP_ADDIU: r.data = a + sImm;
    OP_SLTI:  r.data = {31'b0, $signed(a) < $signed(sImm)};
    OP_SLTIU: r.data = {31'b0, a < sImm}; // sign-extended, compared unsigned
    OP_ANDI:  r.data = a & zImm;
    OP_ORI:   r.data = a | zImm;
    OP_XORI:  r.data = a ^ zImm;
    OP_LUI:   r.data = {r.instr[15:0], 16'h0000};
    OP_BEQ:   r.taken = (a == b);
    OP_BNE:   r.taken = (a != b);
    OP_BLEZ:  r.taken = ($signed(a) <= 0);
    OP_BGTZ:  r.taken = ($signed(a) > 0);
    default:  wr = 1'b0;
  endcase
  if (wr && (r.dest != '0))
    shadowRegs[r.dest] = r.data;
endfunction

`endif

// File: test/coreTb.sv
`timescale 1ns/1ps

module coreTb;
  import corePkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int LATENCY    = 3; // falling edges from drive to stable outputs

  `include "coreModel.svh"

  logic   clk = 1'b0;
  logic   reset;
  logic   instrValid;
  wordT   instr;
  wordT   pc;
  logic   resultValid;
  regIdxT resultReg;
  wordT   resultData;
  logic   branchValid;
  logic   branchTaken;
  wordT   branchTarget;

  rowT         rows[$];
  rowT         idleRow;
  logic [31:0] rngState = 32'hd05c5745;
  wordT        nextPc = 32'h0040_0000;
  bit          tableReady = 1'b0;
  int          rowErrs;
  int          passCount = 0;
  int          failCount = 0;

  execCore i_dut (.*);

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [31:0] nextRandom();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  task automatic addRow(input string name, input wordT word, input expKindT kind);
    rowT r;
    r.name  = name;
    r.instr = word;
    r.pc    = nextPc;
    r.kind  = kind;
    modelStep(r);
    rows.push_back(r);
    nextPc += 4;
  endtask

  // ori depends on the lui right before it
  task automatic loadReg(input regIdxT r, input wordT value);
    addRow($sformatf("lui_r%0d", r), encI(OP_LUI, 5'd0, r, value[31:16]), EXP_WRITE);
    addRow($sformatf("ori_r%0d", r), encI(OP_ORI, r, r, value[15:0]), EXP_WRITE);
  endtask

  task automatic buildTable();
    codeT fns [13] = '{FN_ADDU, FN_SUBU, FN_ADD, FN_SUB, FN_OR, FN_AND, FN_XOR, FN_NOR,
                       FN_SLTU, FN_SLT, FN_SLL, FN_SRL, FN_SRA};
    codeT imms [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    codeT shFns [3] = '{FN_SLL, FN_SRL, FN_SRA};
    logic [4:0] shifts [3] = '{5'd0, 5'd1, 5'd31};
    idleRow.name = "reset_idle";
    idleRow.kind = EXP_NONE;
    addRow("after_reset_r31", encR(FN_ADDU, 5'd31, 5'd0, 5'd1, 5'd0), EXP_WRITE);
    loadReg(5'd8, nextRandom());
    loadReg(5'd9, nextRandom());
    loadReg(5'd10, nextRandom() | 32'h8000_0000);            // negative
    loadReg(5'd11, (nextRandom() & 32'h7fff_ffff) | 32'h1);  // positive
    foreach (fns[i])
    begin
      addRow($sformatf("rtype_fn%02h_rand", fns[i]), encR(fns[i], 5'd8, 5'd9, 5'd12, 5'd7),
             EXP_WRITE);
      addRow($sformatf("rtype_fn%02h_sign", fns[i]), encR(fns[i], 5'd10, 5'd11, 5'd13, 5'd3),
             EXP_WRITE);
    end
    foreach (shifts[i])
      foreach (shFns[j])
        addRow($sformatf("shift_fn%02h_by%0d", shFns[j], shifts[i]),
               encR(shFns[j], 5'd0, 5'd10, 5'd14, shifts[i]), EXP_WRITE);
    foreach (imms[i])
    begin
      addRow($sformatf("imm_op%02h_r8", imms[i]),
             encI(imms[i], 5'd8, 5'd15, 16'(nextRandom()) | 16'h8000), EXP_WRITE);
      addRow($sformatf("imm_op%02h_r10", imms[i]),
             encI(imms[i], 5'd10, 5'd15, 16'(nextRandom()) | 16'h8000), EXP_WRITE);
    end
    addRow("chain_base", encI(OP_ADDIU, 5'd0, 5'd16, 16'd7), EXP_WRITE);
    addRow("chain_neg", encI(OP_ADDIU, 5'd0, 5'd17, 16'hfffd), EXP_WRITE);
    addRow("chain_add", encR(FN_ADDU, 5'd16, 5'd17, 5'd18, 5'd0), EXP_WRITE); // wt and fwd
    addRow("chain_xor", encR(FN_XOR, 5'd18, 5'd17, 5'd19, 5'd0), EXP_WRITE);
    addRow("beq_equal", encI(OP_BEQ, 5'd19, 5'd19, 16'hfff0), EXP_BRANCH);
    addRow("beq_unequal", encI(OP_BEQ, 5'd8, 5'd9, 16'h0010), EXP_BRANCH);
    addRow("bne_equal", encI(OP_BNE, 5'd10, 5'd10, 16'h0001), EXP_BRANCH);
    addRow("bne_unequal", encI(OP_BNE, 5'd10, 5'd11, 16'h8000), EXP_BRANCH);
    addRow("blez_neg", encI(OP_BLEZ, 5'd10, 5'd0, 16'h0020), EXP_BRANCH);
    addRow("blez_zero", encI(OP_BLEZ, 5'd0, 5'd0, 16'hffff), EXP_BRANCH);
    addRow("blez_pos", encI(OP_BLEZ, 5'd11, 5'd11, 16'h0003), EXP_BRANCH); // rt field ignored
    addRow("bgtz_pos", encI(OP_BGTZ, 5'd11, 5'd0, 16'h7fff), EXP_BRANCH);
    addRow("bgtz_zero", encI(OP_BGTZ, 5'd0, 5'd10, 16'h0004), EXP_BRANCH); // rt field ignored
    addRow("bgtz_neg", encI(OP_BGTZ, 5'd10, 5'd0, 16'hff00), EXP_BRANCH);
    addRow("write_r0", encI(OP_ADDIU, 5'd0, 5'd0, 16'd123), EXP_WRITE);
    addRow("read_r0", encR(FN_ADDU, 5'd0, 5'd0, 5'd20, 5'd0), EXP_WRITE);
    addRow("bad_opcode", encI(6'b111111, 5'd8, 5'd9, 16'h1234), EXP_NONE);
    addRow("bad_funct", encR(6'b001000, 5'd8, 5'd0, 5'd21, 5'd0), EXP_NONE);
  endtask

  task automatic noteMismatch(input string name, input string what, input wordT exp,
                              input wordT act);
    $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
    rowErrs++;
  endtask

  task automatic noteProblem(input string name, input string msg);
    $display("%s: %s", name, msg);
    rowErrs++;
  endtask

  task automatic checkRow(input rowT r);
    rowErrs = 0;
    if (r.kind == EXP_WRITE)
    begin
      assert (resultValid) else noteProblem(r.name, "expected a result but none was reported");
      assert (!resultValid || resultReg == r.dest)
        else noteMismatch(r.name, "reg", r.dest, resultReg);
      assert (!resultValid || resultData == r.data)
        else noteMismatch(r.name, "data", r.data, resultData);
    end
    else
      assert (!resultValid) else noteProblem(r.name, "a result was reported unexpectedly");
    if (r.kind == EXP_BRANCH)
    begin
      assert (branchValid) else noteProblem(r.name, "expected a branch report but none came");
      assert (branchTaken == r.taken) else noteMismatch(r.name, "taken", r.taken, branchTaken);
      assert (branchTarget == r.target)
        else noteMismatch(r.name, "target", r.target, branchTarget);
    end
    else
      assert (!branchValid) else noteProblem(r.name, "a branch was reported unexpectedly");
    if (rowErrs == 0)
    begin
      passCount++;
      $display("PASS %s", r.name);
    end
    else
    begin
      failCount++;
      $display("row %s finished with %0d errors", r.name, rowErrs);
    end
  endtask

  initial
  begin
    reset      = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    pc         = '0;
    buildTable();
    tableReady = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    for (int cyc = 0; cyc < rows.size() + LATENCY; cyc++)
    begin
      @(negedge clk);
      if (cyc >= LATENCY)
        checkRow(rows[cyc - LATENCY]);
      else
        checkRow(idleRow); // pipeline still empty
      if (cyc < rows.size())
      begin
        instrValid = 1'b1;
        instr      = rows[cyc].instr;
        pc         = rows[cyc].pc;
      end
      else
        instrValid = 1'b0;
    end
    $display("rows passed: %0d, rows failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // table length plus ten cycles plus the reset cycles
  initial
  begin
    wait (tableReady);
    #((rows.size() + 12) * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", rows.size() + 12);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: files.f
+incdir+test
hdl/corePkg.sv
hdl/pipeIfs.sv
hdl/regFile.sv
hdl/instrDecoder.sv
hdl/aluUnit.sv
hdl/executeStage.sv
hdl/execCore.sv
test/coreTb.sv
